/* Bender.yml */
package:
  name: rx_link

sources:
  - hdl/rx_link_pkg.sv
  - hdl/rx_frame_if.sv
  - hdl/rx_frame_parser.sv
  - hdl/rx_dma_cmd.sv
  - hdl/rx_pack_fifo.sv
  - hdl/loss_holdoff.sv
  - hdl/rx_link_top.sv
  - target: test
    files:
      - verif/tb_rx_link.sv

/* compile.f */
hdl/rx_link_pkg.sv
hdl/rx_frame_if.sv
hdl/rx_frame_parser.sv
hdl/rx_dma_cmd.sv
hdl/rx_pack_fifo.sv
hdl/loss_holdoff.sv
hdl/rx_link_top.sv
verif/tb_rx_link.sv

/* hdl/loss_holdoff.sv */
// HOLDOFF_CYCLES must be at least 1; a condition seen during the holdoff is ignored
`timescale 1ns/1ps

module loss_holdoff #(
    parameter int unsigned HOLDOFF_CYCLES = rx_link_pkg::holdoff_cycles_dflt
) (
    input  logic clk,
    input  logic i_rst,
    input  logic i_detect_ena,
    input  logic i_loss_cond,
    output logic o_loss
);

    logic [$clog2(HOLDOFF_CYCLES+1)-1:0] timer;
    logic                                hold;

    always_ff @(posedge clk) begin
        if (i_rst || !i_detect_ena) begin
            o_loss <= 1'b0;
            hold   <= 1'b0;
            timer  <= '0;
        end else if (i_loss_cond && !hold) begin
            // Disarm in the same cycle as the pulse
            o_loss <= 1'b1;
            hold   <= 1'b1;
            timer  <= '0;
        end else begin
            o_loss <= 1'b0;
            if (hold) begin
                if (timer == $bits(timer)'(HOLDOFF_CYCLES - 1)) begin
                    hold <= 1'b0;
                end else begin
                    timer <= timer + 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/rx_dma_cmd.sv */
// One command per frame; a new length word overwrites a command that was never acknowledged
`timescale 1ns/1ps

module rx_dma_cmd (
    input  logic                                              clk,
    input  logic                                              i_rst,
    rx_frame_if.cmd                                           frame,
    input  logic                                              i_rx_start,
    input  logic [rx_link_pkg::addr_w-1:0]                    i_rx_base_addr,
    input  logic                                              i_wr_cmd_ack,
    output logic                                              o_wr_cmd_req,
    output logic [rx_link_pkg::addr_w+rx_link_pkg::len_w-1:0] o_wr_cmd_data
);
    import rx_link_pkg::*;

    logic [addr_w-1:0] wr_addr;
    logic [len_w-1:0]  wr_len;
    logic [len_w-4:0]  len_units;

    // Round up to whole 8-byte DMA beats
    assign len_units = frame.frame_len[len_w-1:3] + (|frame.frame_len[2:0]);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wr_cmd_req <= 1'b0;
            wr_len       <= '0;
        end else if (frame.len_valid) begin
            o_wr_cmd_req <= 1'b1;
            wr_len       <= {len_units, 3'b000};
        end else if (i_wr_cmd_ack) begin
            o_wr_cmd_req <= 1'b0;
        end
    end

    // Next frame lands right after the previous one
    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_addr <= rx_base_addr_rst;
        end else if (i_rx_start) begin
            wr_addr <= i_rx_base_addr;
        end else if (frame.frame_end) begin
            wr_addr <= wr_addr + {{(addr_w-len_w){1'b0}}, wr_len};
        end
    end

    // Address high, byte count low
    assign o_wr_cmd_data = {wr_addr, wr_len};

endmodule

/* hdl/rx_frame_if.sv */
// No handshake here; strobes are one cycle wide and the consumers must always accept them
`timescale 1ns/1ps

interface rx_frame_if;
    import rx_link_pkg::*;

    logic             word_valid;
    logic [15:0]      word;
    logic             len_valid;
    logic [len_w-1:0] frame_len;
    logic             frame_end;
    logic             in_frame;

    modport parser (
        output word_valid, word, len_valid, frame_len, frame_end, in_frame
    );

    modport cmd (
        input len_valid, frame_len, frame_end
    );

    modport pack (
        input word_valid, word, frame_end
    );

endinterface

/* hdl/rx_frame_parser.sv */
// Frame length must be even and at least 2 bytes; a missing head flag keeps the FSM waiting
`timescale 1ns/1ps

module rx_frame_parser (
    input  logic                            clk,
    input  logic                            i_rst,
    input  logic                            i_rkmsb,
    input  logic                            i_rklsb,
    input  logic [15:0]                     i_rxd,
    rx_frame_if.parser                      frame,
    output logic [3:0]                      o_data_type,
    output logic [1:0]                      o_channel_id,
    output logic                            o_file_end_flag,
    output logic [rx_link_pkg::line_w-1:0]  o_frame_num,
    output logic [rx_link_pkg::len_w-1:0]   o_frame_len,
    output logic                            o_checksum_flag
);
    import rx_link_pkg::*;

    logic [3:0]       state;
    logic [3:0]       state_nxt;
    logic [15:0]      prev_rxd;
    logic [15:0]      csum;
    logic [len_w-2:0] word_cnt;
    logic             sync_hit;
    logic             sof_hit;
    logic             last_word;
    rx_info_word_t    info;

    assign info.raw  = i_rxd;
    // Only the low byte of the sync word is a K character
    assign sync_hit  = ~i_rkmsb & i_rklsb & (i_rxd == sync_word);
    assign sof_hit   = i_rkmsb & i_rklsb & (i_rxd == sof_word);
    assign last_word = (word_cnt == o_frame_len[len_w-1:1] - 1'b1);

    ////////////////////
    // Frame FSM

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (sync_hit) begin
                    state_nxt = st_sync;
                end
            end
            st_sync: begin
                if (sof_hit) begin
                    state_nxt = st_head;
                end
            end
            st_head: begin
                // Flag spans the previous and the current word
                if ({prev_rxd, i_rxd} == head_flag) begin
                    state_nxt = st_type;
                end
            end
            st_type:    state_nxt = st_line;
            st_line:    state_nxt = st_len;
            st_len:     state_nxt = st_payload;
            st_payload: begin
                if (last_word) begin
                    state_nxt = st_check;
                end
            end
            st_check:   state_nxt = st_end1;
            st_end1:    state_nxt = st_end2;
            default:    state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        prev_rxd <= i_rxd;
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            word_cnt <= '0;
        end else if (state == st_payload) begin
            word_cnt <= word_cnt + 1'b1;
        end else begin
            word_cnt <= '0;
        end
    end

    ////////////////////
    // Header capture

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_data_type     <= '0;
            o_channel_id    <= '0;
            o_file_end_flag <= 1'b0;
            o_frame_num     <= '0;
            o_frame_len     <= '0;
        end else begin
            if (state == st_type) begin
                o_file_end_flag    <= info.f.file_end[0];
                o_channel_id       <= info.f.channel_id;
                o_data_type        <= info.f.data_type;
                o_frame_num[23:16] <= info.f.line_hi;
            end
            if (state == st_line) begin
                o_frame_num[15:0] <= i_rxd;
            end
            if (state == st_len) begin
                o_frame_len <= i_rxd;
            end
        end
    end

    // Sum of type, line, length and payload words, mod 2^16
    always_ff @(posedge clk) begin
        if (state == st_head) begin
            csum <= '0;
        end else if (state inside {st_type, st_line, st_len, st_payload}) begin
            csum <= csum + info.raw;
        end
    end

    // Result holds until the next frame is found
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_checksum_flag <= 1'b0;
        end else if ((state == st_idle) && sync_hit) begin
            o_checksum_flag <= 1'b0;
        end else if (state == st_check) begin
            o_checksum_flag <= (csum != i_rxd);
        end
    end

    ////////////////////
    // Events to the DMA side

    assign frame.word_valid = (state == st_payload);
    assign frame.word       = i_rxd;
    assign frame.len_valid  = (state == st_len);
    assign frame.frame_len  = i_rxd;
    assign frame.in_frame   = (state >= st_type) && (state <= st_check);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            frame.frame_end <= 1'b0;
        end else begin
            frame.frame_end <= (state == st_check);
        end
    end

endmodule

/* hdl/rx_link_pkg.sv */
// Codes assume the TLK2711 byte order: low byte first on the wire; LSB flag marks the low byte
package rx_link_pkg;

    ////////////////////
    // 8b/10b control and data characters
    localparam logic [7:0] k28_5 = 8'hBC;
    localparam logic [7:0] d5_6  = 8'hC5;
    localparam logic [7:0] k27_7 = 8'hFB;
    localparam logic [7:0] k28_2 = 8'h5C;

    // Words as seen on i_rxd
    localparam logic [15:0] sync_word = {d5_6, k28_5};
    localparam logic [15:0] sof_word  = {k28_2, k27_7};
    localparam logic [31:0] head_flag = 32'hEB90_E116;
    localparam logic [15:0] loss_word = 16'hFFFF;

    ////////////////////
    // Bus widths
    localparam int addr_w = 32;
    localparam int len_w  = 16;
    localparam int line_w = 24;
    localparam int dma_w  = 64;
    localparam int keep_w = 8;

    localparam logic [31:0] rx_base_addr_rst   = 32'h5000_0000;
    // About 100 ms at 100 MHz
    localparam logic [23:0] holdoff_cycles_dflt = 24'd10_000_000;

    ////////////////////
    // Parser states
    localparam logic [3:0] st_idle    = 4'd0;
    localparam logic [3:0] st_sync    = 4'd1;
    localparam logic [3:0] st_head    = 4'd2;
    localparam logic [3:0] st_type    = 4'd3;
    localparam logic [3:0] st_line    = 4'd4;
    localparam logic [3:0] st_len     = 4'd5;
    localparam logic [3:0] st_payload = 4'd6;
    localparam logic [3:0] st_check   = 4'd7;
    localparam logic [3:0] st_end1    = 4'd8;
    localparam logic [3:0] st_end2    = 4'd9;

    // Type word fields, high bit first
    typedef struct packed {
        logic [1:0] file_end;
        logic [1:0] channel_id;
        logic [3:0] data_type;
        logic [7:0] line_hi;
    } rx_info_fields_t;

    // Raw view feeds the checksum
    typedef union packed {
        logic [15:0]     raw;
        rx_info_fields_t f;
    } rx_info_word_t;

endpackage

/* hdl/rx_link_top.sv */
// Single clock; i_rx_start loads the write address and should come before the first frame
`timescale 1ns/1ps

module rx_link_top #(
    parameter int unsigned HOLDOFF_CYCLES = rx_link_pkg::holdoff_cycles_dflt
) (
    input  logic                                              clk,
    input  logic                                              i_rst,
    // Link receiver words
    input  logic                                              i_rkmsb,
    input  logic                                              i_rklsb,
    input  logic [15:0]                                       i_rxd,
    // DMA command
    input  logic                                              i_rx_start,
    input  logic [rx_link_pkg::addr_w-1:0]                    i_rx_base_addr,
    input  logic                                              i_wr_cmd_ack,
    output logic                                              o_wr_cmd_req,
    output logic [rx_link_pkg::addr_w+rx_link_pkg::len_w-1:0] o_wr_cmd_data,
    // DMA data
    input  logic                                              i_dma_wr_ready,
    output logic                                              o_dma_wr_valid,
    output logic [rx_link_pkg::keep_w-1:0]                    o_dma_wr_keep,
    output logic [rx_link_pkg::dma_w-1:0]                     o_dma_wr_data,
    // Header fields
    output logic [3:0]                                        o_rx_data_type,
    output logic [1:0]                                        o_rx_channel_id,
    output logic                                              o_rx_file_end_flag,
    output logic [rx_link_pkg::line_w-1:0]                    o_rx_frame_num,
    output logic [rx_link_pkg::len_w-1:0]                     o_rx_frame_length,
    output logic                                              o_rx_checksum_flag,
    // Loss detection
    input  logic                                              i_link_loss_detect_ena,
    input  logic                                              i_sync_loss_detect_ena,
    output logic                                              o_loss_interrupt,
    output logic                                              o_link_loss,
    output logic                                              o_sync_loss
);
    import rx_link_pkg::*;

    logic link_loss_cond;
    logic sync_loss_cond;

    rx_frame_if frame_bus ();

    rx_frame_parser u_parser (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_rkmsb         (i_rkmsb),
        .i_rklsb         (i_rklsb),
        .i_rxd           (i_rxd),
        .frame           (frame_bus.parser),
        .o_data_type     (o_rx_data_type),
        .o_channel_id    (o_rx_channel_id),
        .o_file_end_flag (o_rx_file_end_flag),
        .o_frame_num     (o_rx_frame_num),
        .o_frame_len     (o_rx_frame_length),
        .o_checksum_flag (o_rx_checksum_flag)
    );

    rx_dma_cmd u_cmd (
        .clk            (clk),
        .i_rst          (i_rst),
        .frame          (frame_bus.cmd),
        .i_rx_start     (i_rx_start),
        .i_rx_base_addr (i_rx_base_addr),
        .i_wr_cmd_ack   (i_wr_cmd_ack),
        .o_wr_cmd_req   (o_wr_cmd_req),
        .o_wr_cmd_data  (o_wr_cmd_data)
    );

    rx_pack_fifo u_pack (
        .clk            (clk),
        .i_rst          (i_rst),
        .frame          (frame_bus.pack),
        .i_dma_wr_ready (i_dma_wr_ready),
        .o_dma_wr_valid (o_dma_wr_valid),
        .o_dma_wr_keep  (o_dma_wr_keep),
        .o_dma_wr_data  (o_dma_wr_data)
    );

    ////////////////////
    // Loss conditions

    // Receiver sends all ones with both K flags when the link drops
    assign link_loss_cond = i_rkmsb & i_rklsb & (i_rxd == loss_word);
    // No K character is legal between the type word and the checksum
    assign sync_loss_cond = (i_rkmsb | i_rklsb) & frame_bus.in_frame;

    loss_holdoff #(
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) u_link_loss (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_detect_ena (i_link_loss_detect_ena),
        .i_loss_cond  (link_loss_cond),
        .o_loss       (o_link_loss)
    );

    loss_holdoff #(
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) u_sync_loss (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_detect_ena (i_sync_loss_detect_ena),
        .i_loss_cond  (sync_loss_cond),
        .o_loss       (o_sync_loss)
    );

    assign o_loss_interrupt = o_link_loss | o_sync_loss;

endmodule

/* hdl/rx_pack_fifo.sv */
// depth must be a power of two; entries pushed while full are dropped without a flag
`timescale 1ns/1ps

module rx_pack_fifo #(
    parameter int depth = 512
) (
    input  logic                            clk,
    input  logic                            i_rst,
    rx_frame_if.pack                        frame,
    input  logic                            i_dma_wr_ready,
    output logic                            o_dma_wr_valid,
    output logic [rx_link_pkg::keep_w-1:0]  o_dma_wr_keep,
    output logic [rx_link_pkg::dma_w-1:0]   o_dma_wr_data
);
    import rx_link_pkg::*;

    logic [dma_w-1:0]           mem [depth];
    logic [dma_w-1:0]           pack_q;
    logic [dma_w-1:0]           push_data;
    logic [1:0]                 pack_cnt;
    logic [$clog2(depth)-1:0]   wr_ptr;
    logic [$clog2(depth)-1:0]   rd_ptr;
    logic [$clog2(depth):0]     count;
    logic                       entry_full;
    logic                       flush;
    logic                       push;
    logic                       pop;
    logic                       empty;
    logic                       full;

    ////////////////////
    // Word packing

    assign entry_full = frame.word_valid & (pack_cnt == 2'd3);
    // Partial entry at the end of a frame
    assign flush      = frame.frame_end & (pack_cnt != 2'd0);
    assign push       = (entry_full | flush) & ~full;
    assign push_data  = entry_full ? {frame.word, pack_q[dma_w-17:0]} : pack_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pack_cnt <= 2'd0;
        end else if (frame.frame_end) begin
            pack_cnt <= 2'd0;
        end else if (frame.word_valid) begin
            pack_cnt <= pack_cnt + 2'd1;
        end
    end

    // First word of an entry clears the rest, so a flush is zero filled
    always_ff @(posedge clk) begin
        if (frame.word_valid) begin
            if (pack_cnt == 2'd0) begin
                pack_q <= {{(dma_w-16){1'b0}}, frame.word};
            end else begin
                pack_q[{pack_cnt, 4'b0000} +: 16] <= frame.word;
            end
        end
    end

    ////////////////////
    // FWFT storage

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign empty = (count == '0);
    assign full  = (count == depth);

    // Ready is folded into valid, so every valid cycle is a pop
    assign o_dma_wr_valid = ~empty & i_dma_wr_ready;
    assign pop            = o_dma_wr_valid;
    assign o_dma_wr_data  = mem[rd_ptr];
    assign o_dma_wr_keep  = '1;

endmodule

/* verif/rx_link_cases.txt */
// Columns, all hex: data_type channel_id file_end line_num byte_len bad_csum loss_words k_insert
// file_end is two bits, only bit 0 is reported; byte_len is even and at least 2
1 0 0 000001 0002 0 0 0
2 1 1 000002 0004 0 0 0
3 2 0 000003 0006 0 0 0
4 3 2 000004 0008 0 1 0
5 0 3 000005 000a 0 0 0
6 1 0 0000ff 000e 1 0 0
7 2 1 000100 0010 0 0 0
8 3 0 01a2b3 001a 0 0 1
9 0 0 7fffff 0040 0 0 0
a 1 1 800000 003e 1 1 0
b 2 0 abcdef 0080 0 5 0
c 3 0 123456 0012 0 0 1
d 0 1 fedcba 0100 0 0 0
e 1 0 000fff 0022 1 2 0
f 2 0 0f0f0f 0002 0 0 1
0 3 1 ffffff 007e 0 3 1
5 1 2 5a5a5a 000c 0 0 0
a 2 3 a5a5a5 0014 1 0 0
3 0 0 000000 0018 0 1 1
c 3 1 3c3c3c 0030 0 0 0

/* verif/tb_rx_link.sv */
// Runs the DUT with HOLDOFF_CYCLES of 64; every case needs an even byte length of at least 2
`timescale 1ns/1ps

module tb_rx_link;
    import rx_link_pkg::*;

    localparam int holdoff   = 64;
    localparam int max_cases = 32;
    localparam int case_cols = 8;
    localparam logic [31:0] start_addr = 32'h8000_0100;

    logic        clk = 1'b0;
    logic        i_rst;
    logic        i_rkmsb;
    logic        i_rklsb;
    logic [15:0] i_rxd;
    logic        i_rx_start;
    logic [31:0] i_rx_base_addr;
    logic        i_wr_cmd_ack;
    logic        o_wr_cmd_req;
    logic [47:0] o_wr_cmd_data;
    logic        i_dma_wr_ready;
    logic        o_dma_wr_valid;
    logic [7:0]  o_dma_wr_keep;
    logic [63:0] o_dma_wr_data;
    logic [3:0]  o_rx_data_type;
    logic [1:0]  o_rx_channel_id;
    logic        o_rx_file_end_flag;
    logic [23:0] o_rx_frame_num;
    logic [15:0] o_rx_frame_length;
    logic        o_rx_checksum_flag;
    logic        i_link_loss_detect_ena;
    logic        i_sync_loss_detect_ena;
    logic        o_loss_interrupt;
    logic        o_link_loss;
    logic        o_sync_loss;

    logic [31:0] case_mem [max_cases*case_cols];
    logic [31:0] lfsr = 32'h15fa;
    logic [63:0] exp_q [$];
    logic [47:0] exp_cmd;
    logic [31:0] exp_addr;
    logic        ack_pending;
    logic        in_frame_drv;
    logic        exp_link = 1'b0;
    logic        exp_sync = 1'b0;
    int          ack_wait;
    int          edge_idx    = 0;
    int          link_last   = -1000;
    int          sync_last   = -1000;
    int          cycle_limit = 100;
    int          num_cases   = 0;
    int          cmd_cnt     = 0;
    int          beat_cnt    = 0;
    int          check_cnt   = 0;
    int          error_cnt   = 0;
    int          link_pulses = 0;
    int          sync_pulses = 0;

    always #4 clk = ~clk;

    rx_link_top #(
        .HOLDOFF_CYCLES (holdoff)
    ) u_dut (
        .clk                    (clk),
        .i_rst                  (i_rst),
        .i_rkmsb                (i_rkmsb),
        .i_rklsb                (i_rklsb),
        .i_rxd                  (i_rxd),
        .i_rx_start             (i_rx_start),
        .i_rx_base_addr         (i_rx_base_addr),
        .i_wr_cmd_ack           (i_wr_cmd_ack),
        .o_wr_cmd_req           (o_wr_cmd_req),
        .o_wr_cmd_data          (o_wr_cmd_data),
        .i_dma_wr_ready         (i_dma_wr_ready),
        .o_dma_wr_valid         (o_dma_wr_valid),
        .o_dma_wr_keep          (o_dma_wr_keep),
        .o_dma_wr_data          (o_dma_wr_data),
        .o_rx_data_type         (o_rx_data_type),
        .o_rx_channel_id        (o_rx_channel_id),
        .o_rx_file_end_flag     (o_rx_file_end_flag),
        .o_rx_frame_num         (o_rx_frame_num),
        .o_rx_frame_length      (o_rx_frame_length),
        .o_rx_checksum_flag     (o_rx_checksum_flag),
        .i_link_loss_detect_ena (i_link_loss_detect_ena),
        .i_sync_loss_detect_ena (i_sync_loss_detect_ena),
        .o_loss_interrupt       (o_loss_interrupt),
        .o_link_loss            (o_link_loss),
        .o_sync_loss            (o_sync_loss)
    );

    ////////////////////
    // Helpers

    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    task automatic compare(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
        check_cnt++;
        if (actual !== expected) begin
            error_cnt++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic report_counts;
        $display("%0d cases, %0d checks, %0d errors, %0d link-loss and %0d sync-loss pulses",
                 num_cases, check_cnt, error_cnt, link_pulses, sync_pulses);
    endtask

    // One clock, then new ready and the ack side of the command handshake
    task automatic next_cycle;
        logic [31:0] r;
        @(posedge clk);
        #1;
        r = draw_bits(1);
        i_dma_wr_ready = r[0];
        if (i_wr_cmd_ack) begin
            i_wr_cmd_ack = 1'b0;
            compare("o_wr_cmd_req", o_wr_cmd_req, 0);
        end else if (ack_pending) begin
            compare("o_wr_cmd_req", o_wr_cmd_req, 1);
            if (ack_wait == 0) begin
                i_wr_cmd_ack = 1'b1;
                ack_pending  = 1'b0;
            end else begin
                ack_wait--;
            end
        end else if (o_wr_cmd_req) begin
            cmd_cnt++;
            compare("o_wr_cmd_data", o_wr_cmd_data, exp_cmd);
            ack_wait    = draw_bits(3);
            ack_pending = 1'b1;
        end
    endtask

    task automatic send_word(input logic [15:0] w, input logic kmsb, input logic klsb);
        i_rxd   = w;
        i_rkmsb = kmsb;
        i_rklsb = klsb;
        next_cycle();
    endtask

    task automatic run_case(input int idx);
        logic [31:0]   f [case_cols];
        logic [15:0]   words [$];
        logic [15:0]   len;
        logic [15:0]   rounded;
        logic [15:0]   csum;
        logic [31:0]   r;
        logic [63:0]   entry;
        rx_info_word_t info;
        int            n_words;
        int            beats_before;
        for (int c = 0; c < case_cols; c++) begin
            f[c] = case_mem[idx*case_cols + c];
        end
        len     = f[4][15:0];
        n_words = len / 2;
        rounded = (len + 16'd7) & 16'hFFF8;
        info.f.file_end   = f[2][1:0];
        info.f.channel_id = f[1][1:0];
        info.f.data_type  = f[0][3:0];
        info.f.line_hi    = f[3][23:16];
        csum = info.raw + f[3][15:0] + len;
        for (int i = 0; i < n_words; i++) begin
            r = draw_bits(16);
            words.push_back(r[15:0]);
            csum = csum + r[15:0];
        end
        if (f[5][0]) begin
            csum = csum ^ 16'h8001;
        end
        // Four words per entry, first word low, zero fill at the end
        entry = '0;
        for (int i = 0; i < n_words; i++) begin
            entry[(i % 4)*16 +: 16] = words[i];
            if ((i % 4 == 3) || (i == n_words - 1)) begin
                exp_q.push_back(entry);
                entry = '0;
            end
        end
        exp_cmd      = {exp_addr, rounded};
        beats_before = beat_cnt;

        send_word(16'hC5BC, 1'b0, 1'b1);
        compare("o_rx_checksum_flag", o_rx_checksum_flag, 0);
        send_word(16'h5CFB, 1'b1, 1'b1);
        send_word(16'hEB90, 1'b0, 1'b0);
        send_word(16'hE116, 1'b0, 1'b0);
        in_frame_drv = 1'b1;
        send_word(info.raw, 1'b0, 1'b0);
        compare("o_rx_data_type", o_rx_data_type, f[0][3:0]);
        compare("o_rx_channel_id", o_rx_channel_id, f[1][1:0]);
        compare("o_rx_file_end_flag", o_rx_file_end_flag, f[2][0]);
        compare("o_rx_frame_num[23:16]", o_rx_frame_num[23:16], f[3][23:16]);
        send_word(f[3][15:0], 1'b0, 1'b0);
        compare("o_rx_frame_num", o_rx_frame_num, f[3][23:0]);
        send_word(len, 1'b0, 1'b0);
        compare("o_rx_frame_length", o_rx_frame_length, len);
        for (int i = 0; i < n_words; i++) begin
            // Stray K flag on the first payload word
            send_word(words[i], 1'b0, f[7][0] && (i == 0));
        end
        send_word(csum, 1'b0, 1'b0);
        in_frame_drv = 1'b0;
        compare("o_rx_checksum_flag", o_rx_checksum_flag, f[5][0]);
        send_word(16'h0F0F, 1'b0, 1'b0);
        send_word(16'hF0F0, 1'b0, 1'b0);
        exp_addr = exp_addr + rounded;

        repeat (4) send_word(16'h0000, 1'b0, 1'b0);
        while ((exp_q.size() != 0) || ack_pending || i_wr_cmd_ack) begin
            next_cycle();
        end
        compare("command count", cmd_cnt, idx + 1);
        compare("DMA beats of frame", beat_cnt - beats_before, rounded / 8);

        // Loss words 20 cycles apart
        for (int k = 0; k < f[6]; k++) begin
            send_word(16'hFFFF, 1'b1, 1'b1);
            repeat (19) send_word(16'h0000, 1'b0, 1'b0);
        end
    endtask

    ////////////////////
    // Loss model and watchdog

    always @(posedge clk) begin
        edge_idx++;
        if (i_rst) begin
            exp_link  = 1'b0;
            exp_sync  = 1'b0;
            link_last = -1000;
            sync_last = -1000;
        end else begin
            exp_link = i_rkmsb && i_rklsb && (i_rxd == 16'hFFFF) &&
                       (edge_idx - link_last > holdoff);
            exp_sync = (i_rkmsb || i_rklsb) && in_frame_drv &&
                       (edge_idx - sync_last > holdoff);
            if (exp_link) begin
                link_last = edge_idx;
                link_pulses++;
            end
            if (exp_sync) begin
                sync_last = edge_idx;
                sync_pulses++;
            end
        end
        if (edge_idx > cycle_limit) begin
            $display("Timeout: test still running after %0d cycles", edge_idx);
            report_counts();
            $display("*** FAILED ***");
            $finish;
        end
    end

    // All outputs are settled mid-cycle
    always @(negedge clk) begin
        if (!i_rst) begin
            compare("o_link_loss", o_link_loss, exp_link);
            compare("o_sync_loss", o_sync_loss, exp_sync);
            compare("o_loss_interrupt", o_loss_interrupt, exp_link | exp_sync);
            if (o_dma_wr_valid) begin
                beat_cnt++;
                compare("o_dma_wr_keep", o_dma_wr_keep, 8'hFF);
                if (exp_q.size() == 0) begin
                    error_cnt++;
                    $display("DMA beat at %0t with no payload left to send", $time);
                end else begin
                    compare("o_dma_wr_data", o_dma_wr_data, exp_q.pop_front());
                end
            end
        end
    end

    ////////////////////
    // Main sequence

    initial begin
        i_rst                  = 1'b1;
        i_rkmsb                = 1'b0;
        i_rklsb                = 1'b0;
        i_rxd                  = 16'h0000;
        i_rx_start             = 1'b0;
        i_rx_base_addr         = 32'h0;
        i_wr_cmd_ack           = 1'b0;
        i_dma_wr_ready         = 1'b0;
        i_link_loss_detect_ena = 1'b1;
        i_sync_loss_detect_ena = 1'b1;
        ack_pending            = 1'b0;
        ack_wait               = 0;
        in_frame_drv           = 1'b0;
        exp_addr               = start_addr;

        for (int i = 0; i < max_cases*case_cols; i++) begin
            case_mem[i] = '1;
        end
        $readmemh("verif/rx_link_cases.txt", case_mem);
        while ((num_cases < max_cases) && (case_mem[num_cases*case_cols] !== '1)) begin
            num_cases++;
        end
        // Frame overhead, payload words and loss word gaps
        cycle_limit = 40;
        for (int n = 0; n < num_cases; n++) begin
            cycle_limit += 40 + 4 * (case_mem[n*case_cols + 4] / 2) +
                           24 * case_mem[n*case_cols + 6];
        end
        if (num_cases == 0) begin
            error_cnt++;
            $display("No cases could be read from verif/rx_link_cases.txt");
        end

        repeat (4) @(posedge clk);
        #1;
        i_rst = 1'b0;
        compare("o_wr_cmd_req", o_wr_cmd_req, 0);
        compare("o_dma_wr_valid", o_dma_wr_valid, 0);
        compare("o_link_loss", o_link_loss, 0);
        compare("o_sync_loss", o_sync_loss, 0);
        compare("o_wr_cmd_data", o_wr_cmd_data, {32'h5000_0000, 16'h0000});

        i_rx_start     = 1'b1;
        i_rx_base_addr = start_addr;
        next_cycle();
        i_rx_start = 1'b0;
        compare("o_wr_cmd_data[47:16]", o_wr_cmd_data[47:16], start_addr);
        repeat (2) next_cycle();

        for (int n = 0; n < num_cases; n++) begin
            run_case(n);
        end
        repeat (8) next_cycle();
        if (exp_q.size() != 0) begin
            error_cnt++;
            $display("%0d expected DMA entries never came out", exp_q.size());
        end

        report_counts();
        if (error_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
